//--- Bender.yml
package:
  name: mem_stage

sources:
  - include_dirs:
      - hw
    files:
      - hw/mem_stage_pkg.sv
      - hw/mem_axil_if.sv
      - hw/mem_access_seq.sv
      - hw/data_ram.sv
      - hw/load_align.sv
      - hw/mem_stage.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/mem_stage_props.sv
      - sim/mem_stage_checker.sv
      - sim/mem_stage_tb.sv

//--- build.f
+incdir+hw
hw/mem_stage_pkg.sv
hw/mem_axil_if.sv
hw/mem_access_seq.sv
hw/data_ram.sv
hw/load_align.sv
hw/mem_stage.sv
sim/mem_stage_props.sv
sim/mem_stage_checker.sv
sim/mem_stage_tb.sv

//--- hw/data_ram.sv
`timescale 1ns/1ns
`include "mem_stage_config.svh"

module data_ram (
  input  logic      clk,
  input  logic      reset,
  mem_axil_if.slave bus
);
  import mem_stage_pkg::*;

  xlen_t mem [2**`MEM_DEPTH_LOG2];
  xlen_t rdata_q;
  logic  rvalid_q;
  logic  bvalid_q;
  logic  pending;
  logic  rd_fire;
  logic  wr_fire;
  logic [`MEM_DEPTH_LOG2-1:0] ridx;
  logic [`MEM_DEPTH_LOG2-1:0] widx;

  assign pending = rvalid_q || bvalid_q;

  assign bus.arready = !pending;
  assign bus.awready = !pending;
  assign bus.wready  = !pending;

  assign rd_fire = bus.arvalid && bus.arready;
  assign wr_fire = bus.awvalid && bus.awready && bus.wvalid && bus.wready;

  // upper bits beyond the memory size wrap
  assign ridx = bus.araddr[`MEM_DEPTH_LOG2+2:3];
  assign widx = bus.awaddr[`MEM_DEPTH_LOG2+2:3];

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      for (int i = 0; i < $bits(strb_t); i++) begin
        if (bus.wstrb[i])
          mem[widx][i*8 +: 8] <= bus.wdata[i*8 +: 8];
      end
    end
    if (rd_fire)
      rdata_q <= mem[ridx];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rvalid_q <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      if (rd_fire)
        rvalid_q <= 1'b1;
      else if (bus.rready)
        rvalid_q <= 1'b0;

      if (wr_fire)
        bvalid_q <= 1'b1;
      else if (bus.bready)
        bvalid_q <= 1'b0;
    end
  end

  assign bus.rdata  = rdata_q;
  assign bus.rvalid = rvalid_q;
  assign bus.bvalid = bvalid_q;

endmodule

//--- hw/load_align.sv
`timescale 1ns/1ns

module load_align (
  input  logic                   clk,
  input  logic                   reset,
  mem_axil_if.reader             bus,
  input  mem_stage_pkg::mem_op_e ld_op,
  input  mem_stage_pkg::lane_t   ld_lane,
  input  mem_stage_pkg::regno_t  ld_rd,
  output logic                   out_valid,
  output mem_stage_pkg::regno_t  out_rd,
  output mem_stage_pkg::xlen_t   out_data
);
  import mem_stage_pkg::*;

  lane_t lane;
  xlen_t shifted;
  xlen_t ext_data;

  assign bus.rready = 1'b1;   // no downstream back-pressure

  always_comb begin
    case (ld_op)
      op_lb, op_lbu: lane = ld_lane;
      op_lh, op_lhu: lane = {ld_lane[2:1], 1'b0};
      op_lw, op_lwu: lane = {ld_lane[2], 2'b00};
      default:       lane = 3'd0;
    endcase
    shifted = bus.rdata >> {lane, 3'b000};
    case (ld_op)
      op_lb:   ext_data = {{56{shifted[7]}}, shifted[7:0]};
      op_lbu:  ext_data = {56'd0, shifted[7:0]};
      op_lh:   ext_data = {{48{shifted[15]}}, shifted[15:0]};
      op_lhu:  ext_data = {48'd0, shifted[15:0]};
      op_lw:   ext_data = {{32{shifted[31]}}, shifted[31:0]};
      op_lwu:  ext_data = {32'd0, shifted[31:0]};
      default: ext_data = shifted;   // ld
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset)
      out_valid <= 1'b0;
    else
      out_valid <= bus.rvalid && bus.rready;
  end

  always_ff @(posedge clk) begin
    if (bus.rvalid && bus.rready) begin
      out_rd   <= ld_rd;
      out_data <= ext_data;
    end
  end

endmodule

//--- hw/mem_access_seq.sv
`timescale 1ns/1ns
`include "mem_stage_config.svh"

module mem_access_seq (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  mem_stage_pkg::mem_op_e op,
  input  mem_stage_pkg::addr_t   addr,
  input  mem_stage_pkg::xlen_t   store_data,
  input  mem_stage_pkg::regno_t  rd,
  mem_axil_if.master             bus,
  output mem_stage_pkg::mem_op_e ld_op,
  output mem_stage_pkg::lane_t   ld_lane,
  output mem_stage_pkg::regno_t  ld_rd
);
  import mem_stage_pkg::*;

  seq_state_e state;
  addr_t      req_addr;   // doubleword aligned
  xlen_t      wdata_q;
  strb_t      wstrb_q;
  lane_t      st_lane;
  strb_t      st_mask;
  logic       accept;

  assign in_ready = (state == idle);
  assign accept   = in_valid && in_ready;

  // store lane rounded down to the access size
  always_comb begin
    case (op)
      op_sb: begin
        st_mask = 8'h01;
        st_lane = addr[2:0];
      end
      op_sh: begin
        st_mask = 8'h03;
        st_lane = {addr[2:1], 1'b0};
      end
      op_sw: begin
        st_mask = 8'h0f;
        st_lane = {addr[2], 2'b00};
      end
      default: begin
        st_mask = 8'hff;
        st_lane = 3'd0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (accept) begin
            if (op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld})
              state <= rd_addr;
            else if (op inside {op_sb, op_sh, op_sw, op_sd})
              state <= wr_req;   // op_none falls through as a no-op
          end
        end
        rd_addr: if (bus.arready) state <= rd_wait;
        rd_wait: if (bus.rvalid && bus.rready) state <= idle;
        wr_req:  if (bus.awready && bus.wready) state <= wr_resp;
        wr_resp: if (bus.bvalid && bus.bready) state <= idle;
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_addr <= {addr[`MEM_ADDR_W-1:3], 3'b000};
      wdata_q  <= store_data << {st_lane, 3'b000};
      wstrb_q  <= st_mask << st_lane;
      ld_op    <= op;
      ld_lane  <= addr[2:0];   // aligner does the rounding
      ld_rd    <= rd;
    end
  end

  assign bus.araddr  = req_addr;
  assign bus.arvalid = (state == rd_addr);
  assign bus.awaddr  = req_addr;
  assign bus.awvalid = (state == wr_req);
  assign bus.wdata   = wdata_q;
  assign bus.wstrb   = wstrb_q;
  assign bus.wvalid  = (state == wr_req);
  assign bus.bready  = (state == wr_resp);

endmodule

//--- hw/mem_axil_if.sv
`timescale 1ns/1ns

interface mem_axil_if;
  import mem_stage_pkg::*;

  addr_t araddr;
  logic  arvalid;
  logic  arready;

  xlen_t rdata;
  logic  rvalid;
  logic  rready;

  addr_t awaddr;
  logic  awvalid;
  logic  awready;

  xlen_t wdata;
  strb_t wstrb;
  logic  wvalid;
  logic  wready;

  logic  bvalid;
  logic  bready;

  modport master (
    output araddr, arvalid, input arready,
    input  rvalid, rready,
    output awaddr, awvalid, input awready,
    output wdata, wstrb, wvalid, input wready,
    input  bvalid, output bready
  );

  modport reader (
    input  rdata, rvalid,
    output rready
  );

  modport slave (
    input  araddr, arvalid, output arready,
    output rdata, rvalid, input rready,
    input  awaddr, awvalid, output awready,
    input  wdata, wstrb, wvalid, output wready,
    output bvalid, input bready
  );

endinterface

//--- hw/mem_stage.sv
`timescale 1ns/1ns

module mem_stage (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  mem_stage_pkg::mem_op_e op,
  input  mem_stage_pkg::addr_t   addr,
  input  mem_stage_pkg::xlen_t   store_data,
  input  mem_stage_pkg::regno_t  rd,
  output logic                   out_valid,
  output mem_stage_pkg::regno_t  out_rd,
  output mem_stage_pkg::xlen_t   out_data
);
  import mem_stage_pkg::*;

  mem_op_e ld_op;
  lane_t   ld_lane;
  regno_t  ld_rd;

  mem_axil_if bus ();

  mem_access_seq u_seq (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .op         (op),
    .addr       (addr),
    .store_data (store_data),
    .rd         (rd),
    .bus        (bus.master),
    .ld_op      (ld_op),
    .ld_lane    (ld_lane),
    .ld_rd      (ld_rd)
  );

  data_ram u_ram (
    .clk   (clk),
    .reset (reset),
    .bus   (bus.slave)
  );

  load_align u_align (
    .clk       (clk),
    .reset     (reset),
    .bus       (bus.reader),
    .ld_op     (ld_op),
    .ld_lane   (ld_lane),
    .ld_rd     (ld_rd),
    .out_valid (out_valid),
    .out_rd    (out_rd),
    .out_data  (out_data)
  );

endmodule

//--- hw/mem_stage_config.svh
`ifndef MEM_STAGE_CONFIG_SVH
`define MEM_STAGE_CONFIG_SVH

// register and memory doubleword width
`define MEM_XLEN 64

// byte address width seen by the stage
`define MEM_ADDR_W 12

// log2 of doublewords in the local data memory
`define MEM_DEPTH_LOG2 9

// destination register number width
`define MEM_REGNO_W 5

`endif

//--- hw/mem_stage_pkg.sv
`include "mem_stage_config.svh"

package mem_stage_pkg;

  typedef logic [`MEM_XLEN-1:0]    xlen_t;
  typedef logic [`MEM_ADDR_W-1:0]  addr_t;
  typedef logic [`MEM_REGNO_W-1:0] regno_t;
  typedef logic [2:0]              lane_t;    // byte offset in a doubleword
  typedef logic [`MEM_XLEN/8-1:0]  strb_t;

  typedef enum logic [3:0] {
    op_none,
    op_lb,
    op_lbu,
    op_lh,
    op_lhu,
    op_lw,
    op_lwu,
    op_ld,
    op_sb,
    op_sh,
    op_sw,
    op_sd
  } mem_op_e;

  typedef enum logic [2:0] {
    idle,
    rd_addr,
    rd_wait,
    wr_req,
    wr_resp
  } seq_state_e;

endpackage

//--- sim/mem_stage_checker.sv
`timescale 1ns/1ns

module mem_stage_checker (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   in_valid,
  input  logic                   in_ready,
  input  mem_stage_pkg::mem_op_e op,
  input  logic                   out_valid,
  input  mem_stage_pkg::regno_t  out_rd,
  input  mem_stage_pkg::xlen_t   out_data,
  output int                     error_count
);
  import mem_stage_pkg::*;

  regno_t exp_rd_q [$];
  xlen_t  exp_data_q [$];
  int     exp_test_q [$];
  int     due_q [$];      // edge at which each accepted load must return
  int     cycle = 0;
  int     ready_at = 0;
  int     check_count = 0;
  int     test_count = 0;
  int     test_checks = 0;
  int     test_errors = 0;

  initial error_count = 0;

  task automatic flag_error(string msg);
    $display("%s", msg);
    error_count++;
    test_errors++;
  endtask

  task automatic expect_result(regno_t r, xlen_t d, int test_num);
    exp_rd_q.push_back(r);
    exp_data_q.push_back(d);
    exp_test_q.push_back(test_num);
  endtask

  function automatic int outstanding();
    return exp_data_q.size();
  endfunction

  task automatic end_test(int num, string name);
    $display("test %0d %s: %0d checks, %0d errors", num, name, test_checks, test_errors);
    test_count++;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic final_report(int assert_fails);
    if (exp_data_q.size() != 0)
      flag_error($sformatf("%0d expected load results never arrived", exp_data_q.size()));
    if (assert_fails != 0)
      flag_error($sformatf("%0d concurrent assertions failed during the run", assert_fails));
    $display("totals: %0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
  endtask

  always @(posedge clk) begin
    regno_t e_rd;
    xlen_t  e_data;
    int     e_test;
    int     due;
    if (!reset) begin
      if (cycle < ready_at && in_ready)
        flag_error("in_ready high while an access is still in flight");
      else if (cycle >= ready_at && !in_ready)
        flag_error("in_ready low with no access in flight");
      if (in_valid && in_ready && op != op_none) begin
        ready_at = cycle + 3;
        if (op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld})
          due_q.push_back(cycle + 3);
      end
      if (out_valid) begin
        if (due_q.size() == 0 || exp_data_q.size() == 0) begin
          flag_error("out_valid pulsed with no load outstanding");
        end else begin
          due    = due_q.pop_front();
          e_rd   = exp_rd_q.pop_front();
          e_data = exp_data_q.pop_front();
          e_test = exp_test_q.pop_front();
          check_count++;
          test_checks++;
          if (due != cycle)
            flag_error($sformatf("load of test %0d returned %0d cycles after acceptance, not 3",
                                 e_test, cycle - due + 3));
          if (out_rd !== e_rd)
            flag_error($sformatf("Mismatch out_rd exp 0x%h got 0x%h (test %0d)",
                                 e_rd, out_rd, e_test));
          if (out_data !== e_data)
            flag_error($sformatf("Mismatch out_data exp 0x%h got 0x%h (test %0d)",
                                 e_data, out_data, e_test));
        end
      end
    end
    cycle++;
  end

endmodule

//--- sim/mem_stage_props.sv
`timescale 1ns/1ns

module mem_stage_props (
  input logic                 clk,
  input logic                 reset,
  input logic                 in_ready,
  input logic                 out_valid,
  input logic                 arvalid,
  input logic                 arready,
  input mem_stage_pkg::addr_t araddr,
  input logic                 busy   // any AXI channel valid
);

  int fail_count = 0;

  ar_hold: assert property (@(posedge clk) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else begin
      $error("arvalid or araddr changed before arready");
      fail_count++;
    end

  busy_stall: assert property (@(posedge clk) disable iff (reset) busy |-> !in_ready)
    else begin
      $error("in_ready high while an AXI transfer is outstanding");
      fail_count++;
    end

  single_pulse: assert property (@(posedge clk) disable iff (reset) out_valid |=> !out_valid)
    else begin
      $error("out_valid held for two cycles");
      fail_count++;
    end

endmodule

bind mem_stage mem_stage_props i_props (
  .clk       (clk),
  .reset     (reset),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .arvalid   (bus.arvalid),
  .arready   (bus.arready),
  .araddr    (bus.araddr),
  .busy      (bus.arvalid || bus.rvalid || bus.awvalid || bus.wvalid || bus.bvalid)
);

//--- sim/mem_stage_tb.sv
`timescale 1ns/1ns
`include "mem_stage_config.svh"

module mem_stage_tb;
  import mem_stage_pkg::*;

  localparam int n_sd = 16;
  localparam int n_merge = 4;
  localparam int n_mix = 40;
  // sd/ld pairs, merge groups, lane sweep, window fill, random mix
  localparam int total_requests = 2*n_sd + 5*n_merge + 49 + 8 + n_mix;
  localparam int timeout_limit = 5*total_requests + 100;

  logic        clk = 1'b0;
  logic        reset;
  logic        in_valid;
  logic        in_ready;
  logic        out_valid;
  mem_op_e     op;
  addr_t       addr;
  xlen_t       store_data;
  xlen_t       out_data;
  regno_t      rd;
  regno_t      out_rd;
  int          error_count;
  int          cycles = 0;
  logic [15:0] lfsr = 16'd56337;
  logic [7:0]  shadow [2**`MEM_ADDR_W];   // byte image of the data memory
  mem_op_e     sub_ops [6] = '{op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu};
  addr_t       sd_addr [n_sd];
  addr_t       base;
  logic [3:0]  opc;

  always #50 clk = ~clk;

  mem_stage i_dut (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .op         (op),
    .addr       (addr),
    .store_data (store_data),
    .rd         (rd),
    .out_valid  (out_valid),
    .out_rd     (out_rd),
    .out_data   (out_data)
  );

  mem_stage_checker i_chk (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .op          (op),
    .out_valid   (out_valid),
    .out_rd      (out_rd),
    .out_data    (out_data),
    .error_count (error_count)
  );

  always @(posedge clk) begin
    cycles++;
    if (cycles > timeout_limit) begin
      $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[62:0], fb};
    end
    return r;
  endfunction

  function automatic int op_size(mem_op_e o);
    case (o)
      op_lb, op_lbu, op_sb: return 1;
      op_lh, op_lhu, op_sh: return 2;
      op_lw, op_lwu, op_sw: return 4;
      default:              return 8;
    endcase
  endfunction

  function automatic xlen_t ref_load(mem_op_e o, addr_t a);
    int    size;
    addr_t lo;
    xlen_t v;
    size = op_size(o);
    lo   = a & ~addr_t'(size - 1);   // natural alignment
    v    = '0;
    for (int i = 0; i < size; i++)
      v[8*i +: 8] = shadow[lo + i];
    if (o inside {op_lb, op_lh, op_lw} && v[8*size-1]) begin
      for (int j = 8*size; j < 64; j++)
        v[j] = 1'b1;
    end
    return v;
  endfunction

  task automatic issue(mem_op_e o, addr_t a, xlen_t d, regno_t r, int test_num);
    int    size;
    addr_t lo;
    while (!in_ready) begin
      @(posedge clk);
      #10;
    end
    in_valid   = 1'b1;
    op         = o;
    addr       = a;
    store_data = d;
    rd         = r;
    if (o inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld}) begin
      i_chk.expect_result(r, ref_load(o, a), test_num);
    end else begin
      size = op_size(o);
      lo   = a & ~addr_t'(size - 1);
      for (int i = 0; i < size; i++)
        shadow[lo + i] = d[8*i +: 8];
    end
    @(posedge clk);
    #10;
    in_valid = 1'b0;
  endtask

  task automatic wait_cycles(int n);
    repeat (n) begin
      @(posedge clk);
      #10;
    end
  endtask

  task automatic close_test(int num, string name);
    while (!in_ready || i_chk.outstanding() != 0) begin
      @(posedge clk);
      #10;
    end
    i_chk.end_test(num, name);
  endtask

  initial begin
    reset      = 1'b1;
    in_valid   = 1'b0;
    op         = op_none;
    addr       = '0;
    store_data = '0;
    rd         = '0;
    repeat (5) @(posedge clk);
    #10;
    reset = 1'b0;

    wait_cycles(8);   // checker watches in_ready and out_valid here
    close_test(1, "reset state");

    for (int i = 0; i < n_sd; i++) begin
      sd_addr[i] = addr_t'(rand_bits(12));
      issue(op_sd, sd_addr[i], rand_bits(64), regno_t'(rand_bits(5)), 2);
    end
    for (int i = 0; i < n_sd; i++)
      issue(op_ld, sd_addr[i], '0, regno_t'(rand_bits(5)), 2);
    close_test(2, "sd then ld");

    for (int k = 0; k < n_merge; k++) begin
      base = addr_t'(rand_bits(12)) & 12'hff8;
      issue(op_sd, base, rand_bits(64), regno_t'(rand_bits(5)), 3);
      issue(op_sb, base + addr_t'(rand_bits(3)), rand_bits(64), regno_t'(rand_bits(5)), 3);
      issue(op_sh, base + addr_t'(rand_bits(3)), rand_bits(64), regno_t'(rand_bits(5)), 3);
      issue(op_sw, base + addr_t'(rand_bits(3)), rand_bits(64), regno_t'(rand_bits(5)), 3);
      issue(op_ld, base, '0, regno_t'(rand_bits(5)), 3);
    end
    close_test(3, "sub-word store merge");

    base = addr_t'(rand_bits(12)) & 12'hff8;
    issue(op_sd, base, rand_bits(64), regno_t'(rand_bits(5)), 4);
    for (int k = 0; k < 6; k++) begin
      for (int lane = 0; lane < 8; lane++)
        issue(sub_ops[k], base + addr_t'(lane), '0, regno_t'(rand_bits(5)), 4);
    end
    close_test(4, "sub-word loads");

    base = addr_t'(rand_bits(12)) & 12'hfc0;   // 8-doubleword window
    for (int i = 0; i < 8; i++)
      issue(op_sd, base + addr_t'(8*i), rand_bits(64), regno_t'(rand_bits(5)), 5);
    for (int i = 0; i < n_mix; i++) begin
      wait_cycles(int'(rand_bits(2)));
      opc = 4'(rand_bits(4) % 11) + 4'd1;
      issue(mem_op_e'(opc), base + addr_t'(rand_bits(6)), rand_bits(64),
            regno_t'(rand_bits(5)), 5);
    end
    close_test(5, "random mix");

    i_chk.final_report(i_dut.i_props.fail_count);
    if (error_count == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule
